// File: hdl/vpu_config.svh
// vpu core build parameters
`ifndef VPU_CONFIG_SVH
`define VPU_CONFIG_SVH

// scalar and lane word width
`define VPU_DATA_W 16

// word address width on the memory port
`define VPU_ADDR_W 12

// entries in each register file
`define VPU_NREG 4

// vector lanes, operand routing assumes four
`define VPU_LANES 4

// first fetch address after reset
`define VPU_RESET_PC 0

`endif

// File: hdl/vpu_isa_pkg.sv
// vpu instruction set types
`default_nettype none

package vpu_isa_pkg;

    typedef logic [5:0] opcode_t;

    // register form
    typedef struct packed {
        opcode_t    opcode;
        logic [1:0] rd;
        logic [1:0] rs1;
        logic [1:0] rs2;
        logic [1:0] spare;
        logic [1:0] imm2;
    } instr_reg_t;

    // immediate form, imm6[1:0] doubles as imm2
    typedef struct packed {
        opcode_t    opcode;
        logic [1:0] rd;
        logic [1:0] rs1;
        logic [5:0] imm6;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_t;

    // opcode classes, compared against the top bits
    localparam logic [2:0] CLS_VV      = 3'b000;
    localparam logic [3:0] CLS_VF      = 4'b0010;
    localparam logic [3:0] CLS_NAOX    = 4'b0011;
    localparam logic [2:0] CLS_FF      = 3'b010;
    localparam logic [2:0] CLS_ASMD    = 3'b011;
    localparam logic [3:0] CLS_SPECIAL = 4'b1000;
    localparam logic [3:0] CLS_VSPEC   = 4'b1001;
    localparam logic [2:0] CLS_INT_IMM = 3'b101;
    localparam logic [3:0] CLS_LOAD    = 4'b1011;
    localparam logic [3:0] CLS_STORE   = 4'b1111;

    // single opcodes
    localparam opcode_t OP_REDUCE      = 6'b100100;
    localparam opcode_t OP_S_FROM_LANE = 6'b100101;
    localparam opcode_t OP_SQRT        = 6'b100110;
    localparam opcode_t OP_V_FROM_S    = 6'b100111;
    localparam opcode_t OP_CTX_SWITCH  = 6'b111010;
    localparam opcode_t OP_LANE_FLAG   = 6'b010101;
    localparam opcode_t OP_INT_FLAG    = 6'b011101;

    // low opcode bits, xor is the remaining code in both sets
    localparam logic [1:0] FN_ADD = 2'b00;
    localparam logic [1:0] FN_SUB = 2'b01;
    localparam logic [1:0] FN_MUL = 2'b10;
    localparam logic [1:0] FN_AND = 2'b00;
    localparam logic [1:0] FN_OR  = 2'b01;
    localparam logic [1:0] FN_NOT = 2'b10;

    typedef struct packed {
        logic active;
        logic write;
        logic vector;
    } mem_op_t;

    typedef struct packed {
        logic       int_op2_sel;
        logic [3:0] lane_op1_sel;
        logic [1:0] lane1_op2_sel;
        logic       lane2_op2_sel;
        logic [1:0] lane3_op2_sel;
        logic       lane4_op2_sel;
        logic       int_en;
        logic [3:0] lane_en;
        logic [2:0] scalar_out_sel;
        mem_op_t    mem_op;
        logic       reduce_en;
        logic       update_int_flag;
        logic       update_lane_flag;
        logic       context_switch;
    } decode_ctrl_t;

endpackage

`default_nettype wire

// File: hdl/vpu_bus_pkg.sv
// wishbone classic bus types
`default_nettype none

`include "vpu_config.svh"

package vpu_bus_pkg;

    // master to slave
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`VPU_ADDR_W-1:0] adr;
        logic [`VPU_DATA_W-1:0] dat_w;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                   ack;
        logic [`VPU_DATA_W-1:0] dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: hdl/instruction_decode_unit.sv
// instruction decode unit
`default_nettype none

module instruction_decode_unit import vpu_isa_pkg::*; (
    input  instr_t       instr,
    output decode_ctrl_t ctrl
);

    opcode_t    op;
    logic [1:0] imm2;

    assign op   = instr.r.opcode;
    assign imm2 = instr.r.imm2;

    always_comb begin
        // defaults, overridden per class below
        ctrl = '0;
        ctrl.int_op2_sel = 1'b1;

        // only register-form int ops read scalar 2
        if (op[5:3] == CLS_ASMD || op[5:2] == CLS_NAOX) begin
            ctrl.int_op2_sel = 1'b0;
        end

        // lane op1 from scalar 1
        if (op[5:3] == CLS_FF || op == OP_SQRT) begin
            ctrl.lane_op1_sel[0] = 1'b1;
        end
        if (op == OP_V_FROM_S) begin
            ctrl.lane_op1_sel[imm2] = 1'b1;
        end

        // reduce pairs neighbouring lanes of vector 1
        if (op == OP_REDUCE) begin
            ctrl.lane1_op2_sel = 2'b10;
            ctrl.lane3_op2_sel = 2'b10;
        end else if (op[5:3] == CLS_FF || op[5:2] == CLS_VF) begin
            ctrl.lane1_op2_sel = 2'b01;
        end

        // VF broadcasts scalar 2 to the other lanes
        if (op[5:2] == CLS_VF) begin
            ctrl.lane2_op2_sel = 1'b1;
            ctrl.lane3_op2_sel = 2'b01;
            ctrl.lane4_op2_sel = 1'b1;
        end

        // NAOX, ASMD, special, int immediate and memory address
        if (op[5:2] == CLS_NAOX || op[5:3] == CLS_ASMD || op[5:2] == CLS_SPECIAL
            || op[5:3] == CLS_INT_IMM || op[5:2] == CLS_STORE) begin
            ctrl.int_en = 1'b1;
        end

        if (op[5:3] == CLS_VV || op[5:2] == CLS_VF || op[5:3] == CLS_FF
            || op[5:2] == CLS_VSPEC) begin
            ctrl.lane_en[0] = 1'b1;
        end
        if (op[5:3] == CLS_VV || op[5:2] == CLS_VF || op == OP_V_FROM_S) begin
            ctrl.lane_en[1] = 1'b1;
            ctrl.lane_en[3] = 1'b1;
        end
        if (op[5:3] == CLS_VV || op[5:2] == CLS_VF || op == OP_V_FROM_S
            || op == OP_REDUCE) begin
            ctrl.lane_en[2] = 1'b1;
        end

        // lane 1 result for FF and sqrt, any lane for scalar-from-lane
        if (op[5:3] == CLS_FF || op == OP_SQRT) begin
            ctrl.scalar_out_sel = 3'b100;
        end
        if (op == OP_S_FROM_LANE) begin
            ctrl.scalar_out_sel = {1'b1, imm2};
        end

        if (op[5:2] == CLS_LOAD || op[5:2] == CLS_STORE) begin
            ctrl.mem_op.active = 1'b1;
            ctrl.mem_op.write  = op[4];
            ctrl.mem_op.vector = op[1];
        end

        ctrl.reduce_en        = (op == OP_REDUCE);
        ctrl.update_lane_flag = (op == OP_LANE_FLAG);
        ctrl.update_int_flag  = (op == OP_INT_FLAG);
        ctrl.context_switch   = (op == OP_CTX_SWITCH);
    end

    // memory ops use the int adder only
    always_comb begin
        if (ctrl.mem_op.active) begin
            assert final (ctrl.lane_en == '0)
                else $error("memory opcode %b enables a lane", op);
            assert final (ctrl.scalar_out_sel == '0)
                else $error("memory opcode %b selects a scalar result", op);
        end
    end

endmodule

`default_nettype wire

// File: hdl/wb_arbiter.sv
// two-master wishbone arbiter
`default_nettype none

module wb_arbiter import vpu_bus_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t m_fetch_req,
    input  wb_req_t m_ls_req,
    output wb_rsp_t m_fetch_rsp,
    output wb_rsp_t m_ls_rsp,
    output wb_req_t s_req,
    input  wb_rsp_t s_rsp
);

    logic locked;
    logic gnt_ls;
    logic sel_ls;

    always_comb begin
        // held grant keeps its owner, load/store wins a fresh tie
        sel_ls = locked ? gnt_ls : m_ls_req.cyc;
        s_req  = sel_ls ? m_ls_req : m_fetch_req;

        m_fetch_rsp.ack   = s_rsp.ack & ~sel_ls;
        m_fetch_rsp.dat_r = sel_ls ? '0 : s_rsp.dat_r;
        m_ls_rsp.ack      = s_rsp.ack & sel_ls;
        m_ls_rsp.dat_r    = sel_ls ? s_rsp.dat_r : '0;
    end

    // grant stays while the owner keeps cyc up
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            locked <= 1'b0;
            gnt_ls <= 1'b0;
        end else begin
            locked <= s_req.cyc;
            gnt_ls <= sel_ls;
        end
    end

    a_ack_to_owner: assert property (@(posedge clk) disable iff (!rst_n)
        (m_fetch_rsp.ack |-> m_fetch_req.cyc) and (m_ls_rsp.ack |-> m_ls_req.cyc));

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
// instruction fetch unit
`default_nettype none

`include "vpu_config.svh"

module fetch_unit import vpu_isa_pkg::*, vpu_bus_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    instr_done,
    output wb_req_t bus_req,
    input  wb_rsp_t bus_rsp,
    output instr_t  instr,
    output logic    instr_valid
);

    localparam int AW = `VPU_ADDR_W;

    logic [AW-1:0] pc;
    logic          busy;

    // read-only master, address is the pc itself
    always_comb begin
        bus_req.cyc   = busy;
        bus_req.stb   = busy;
        bus_req.we    = 1'b0;
        bus_req.adr   = pc;
        bus_req.dat_w = '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= AW'(`VPU_RESET_PC);
            busy        <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            if (!busy && !instr_valid) begin
                busy <= 1'b1;
            end else if (busy && bus_rsp.ack) begin
                busy        <= 1'b0;
                instr_valid <= 1'b1;
                pc          <= pc + AW'(1);
            end
            // retire the held word
            if (instr_done) begin
                instr_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy && bus_rsp.ack) begin
            instr <= instr_t'(bus_rsp.dat_r);
        end
    end

endmodule

`default_nettype wire

// File: hdl/execute_unit.sv
// scalar and vector execute unit
`default_nettype none

`include "vpu_config.svh"

module execute_unit import vpu_isa_pkg::*, vpu_bus_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         instr_valid,
    input  instr_t       instr,
    input  decode_ctrl_t ctrl,
    output wb_req_t      bus_req,
    input  wb_rsp_t      bus_rsp,
    output logic         instr_done,
    output logic         yield,
    output logic         int_zero,
    output logic         lane_zero
);

    localparam int DW    = `VPU_DATA_W;
    localparam int AW    = `VPU_ADDR_W;
    localparam int LANES = `VPU_LANES;

    typedef logic [DW-1:0] word_t;
    typedef word_t [LANES-1:0] vec_t;

    word_t sreg [`VPU_NREG];
    vec_t  vreg [`VPU_NREG];

    opcode_t    op;
    logic [1:0] rd;
    logic [1:0] beat;
    word_t      s1, s2, imm, int_op2, int_res, scalar_res;
    vec_t       v1, v2, lane_op1, lane_op2, lane_res;
    logic       lane_move, scalar_we, mem_last;

    function automatic word_t arith(input logic [1:0] fn, input word_t a, input word_t b);
        case (fn)
            FN_ADD:  return a + b;
            FN_SUB:  return a - b;
            FN_MUL:  return a * b;
            default: return a ^ b;
        endcase
    endfunction

    function automatic word_t logic_op(input logic [1:0] fn, input word_t a, input word_t b);
        case (fn)
            FN_AND:  return a & b;
            FN_OR:   return a | b;
            FN_NOT:  return ~a;
            default: return a ^ b;
        endcase
    endfunction

    always_comb begin
        op  = instr.r.opcode;
        rd  = instr.r.rd;
        s1  = sreg[instr.r.rs1];
        s2  = sreg[instr.r.rs2];
        v1  = vreg[instr.r.rs1];
        v2  = vreg[instr.r.rs2];
        imm = word_t'(instr.i.imm6);

        int_op2 = ctrl.int_op2_sel ? imm : s2;
        int_res = (op[5:2] == CLS_NAOX) ? logic_op(op[1:0], s1, int_op2)
                                        : arith(op[1:0], s1, int_op2);

        for (int n = 0; n < LANES; n++) begin
            lane_op1[n] = ctrl.lane_op1_sel[n] ? s1 : v1[n];
        end
        case (ctrl.lane1_op2_sel)
            2'b01:   lane_op2[0] = s2;
            2'b10:   lane_op2[0] = v1[1];
            default: lane_op2[0] = v2[0];
        endcase
        lane_op2[1] = ctrl.lane2_op2_sel ? s2 : v2[1];
        case (ctrl.lane3_op2_sel)
            2'b01:   lane_op2[2] = s2;
            2'b10:   lane_op2[2] = v1[3];
            default: lane_op2[2] = v2[2];
        endcase
        lane_op2[3] = ctrl.lane4_op2_sel ? s2 : v2[3];

        // sqrt, scalar-from-lane and vector-from-scalar pass op1 through
        lane_move = (op[5:2] == CLS_VSPEC) && !ctrl.reduce_en;
        for (int n = 0; n < LANES; n++) begin
            lane_res[n] = lane_move ? lane_op1[n] : arith(op[1:0], lane_op1[n], lane_op2[n]);
        end

        if (ctrl.reduce_en) begin
            scalar_res = lane_res[0] + lane_res[2];
        end else if (ctrl.scalar_out_sel[2]) begin
            scalar_res = lane_res[ctrl.scalar_out_sel[1:0]];
        end else begin
            scalar_res = int_res;
        end
        scalar_we = ctrl.int_en | ctrl.scalar_out_sel[2] | ctrl.reduce_en;

        // one word per transfer, vectors walk four addresses
        bus_req.cyc   = instr_valid & ctrl.mem_op.active;
        bus_req.stb   = instr_valid & ctrl.mem_op.active;
        bus_req.we    = ctrl.mem_op.write;
        bus_req.adr   = AW'(s1 + imm + word_t'(beat));
        bus_req.dat_w = ctrl.mem_op.vector ? vreg[rd][beat] : sreg[rd];

        mem_last   = !ctrl.mem_op.vector || beat == 2'd3;
        instr_done = instr_valid & (!ctrl.mem_op.active | (bus_rsp.ack & mem_last));
    end

    always_ff @(posedge clk) begin
        if (instr_valid && ctrl.mem_op.active) begin
            if (bus_rsp.ack && !ctrl.mem_op.write) begin
                if (ctrl.mem_op.vector) begin
                    vreg[rd][beat] <= bus_rsp.dat_r;
                end else begin
                    sreg[rd] <= bus_rsp.dat_r;
                end
            end
        end else if (instr_valid) begin
            if (scalar_we) begin
                sreg[rd] <= scalar_res;
            end else begin
                for (int n = 0; n < LANES; n++) begin
                    if (ctrl.lane_en[n]) begin
                        vreg[rd][n] <= lane_res[n];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat      <= 2'd0;
            yield     <= 1'b0;
            int_zero  <= 1'b0;
            lane_zero <= 1'b0;
        end else begin
            yield <= instr_valid & ctrl.context_switch;
            if (instr_valid && ctrl.update_int_flag) begin
                int_zero <= (int_res == '0);
            end
            if (instr_valid && ctrl.update_lane_flag) begin
                lane_zero <= (lane_res[0] == '0);
            end
            if (bus_req.cyc && bus_rsp.ack) begin
                beat <= mem_last ? 2'd0 : beat + 2'd1;
            end
        end
    end

    // fetch retires the instruction right after done
    a_done_retires: assert property (@(posedge clk) disable iff (!rst_n)
        instr_done |-> instr_valid ##1 !instr_valid);

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req.cyc && !bus_rsp.ack |=> $stable(bus_req.adr) && $stable(bus_req.dat_w));

endmodule

`default_nettype wire

// File: hdl/vpu_top.sv
// vpu core slice top
`default_nettype none

module vpu_top import vpu_isa_pkg::*, vpu_bus_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    output wb_req_t wb_req,
    input  wb_rsp_t wb_rsp,
    output logic    yield,
    output logic    int_zero,
    output logic    lane_zero
);

    instr_t       instr;
    logic         instr_valid;
    logic         instr_done;
    decode_ctrl_t ctrl;
    wb_req_t      fetch_req, ls_req;
    wb_rsp_t      fetch_rsp, ls_rsp;

    fetch_unit u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_done  (instr_done),
        .bus_req     (fetch_req),
        .bus_rsp     (fetch_rsp),
        .instr       (instr),
        .instr_valid (instr_valid)
    );

    instruction_decode_unit u_decode (
        .instr (instr),
        .ctrl  (ctrl)
    );

    execute_unit u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ctrl        (ctrl),
        .bus_req     (ls_req),
        .bus_rsp     (ls_rsp),
        .instr_done  (instr_done),
        .yield       (yield),
        .int_zero    (int_zero),
        .lane_zero   (lane_zero)
    );

    wb_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .m_fetch_req (fetch_req),
        .m_ls_req    (ls_req),
        .m_fetch_rsp (fetch_rsp),
        .m_ls_rsp    (ls_rsp),
        .s_req       (wb_req),
        .s_rsp       (wb_rsp)
    );

endmodule

`default_nettype wire

// File: tests/tb_vpu_top.sv
// vpu core slice testbench
`default_nettype none

`include "vpu_config.svh"

module tb_vpu_top
    import vpu_isa_pkg::*, vpu_bus_pkg::*;
();

    localparam int DW = `VPU_DATA_W;
    localparam int AW = `VPU_ADDR_W;
    localparam int NROWS = 35;
    localparam int TIMEOUT_CYCLES = 200 * NROWS;

    // opcodes built from the class rules
    localparam opcode_t I_ADD = 6'b011000, I_SUB = 6'b011001, I_MUL = 6'b011010;
    localparam opcode_t I_AND = 6'b001100, I_NOT = 6'b001110;
    localparam opcode_t I_ADDI = 6'b101000, I_MULI = 6'b101010, I_XORI = 6'b101011;
    localparam opcode_t I_LD = 6'b101100, I_VLD = 6'b101110;
    localparam opcode_t I_ST = 6'b111100, I_VST = 6'b111110;
    localparam opcode_t I_VV_ADD = 6'b000000, I_VF_MUL = 6'b001010;
    localparam opcode_t I_RED = 6'b100100, I_SFL = 6'b100101, I_VFS = 6'b100111;
    localparam opcode_t I_IFLAG = 6'b011101, I_LFLAG = 6'b010101, I_CTX = 6'b111010;

    // data words preloaded behind the program
    localparam logic [DW-1:0] D0 = 16'h1234, D1 = 16'h0F0F;
    localparam logic [DW-1:0] V0 = 16'h0005, V1 = 16'h7FFF, V2 = 16'h8001, V3 = 16'h0002;
    localparam logic [DW-1:0] W0 = 16'hFFFF, W1 = 16'h0011, W2 = 16'h2222, W3 = 16'h0300;

    typedef struct packed {
        instr_t             instr;
        logic [2:0]         nst;
        logic [AW-1:0]      adr;
        logic [3:0][DW-1:0] dat;
        logic               iz;
        logic               lz;
        logic               yl;
    } row_t;

    logic    clk;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    yield, int_zero, lane_zero;

    logic [DW-1:0] mem [256];
    wb_req_t       stores [$];
    row_t          rows [NROWS];
    int            nrows, errors, checks, cycles, delay;
    logic          pending, cur_iz, cur_lz;

    vpu_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .yield     (yield),
        .int_zero  (int_zero),
        .lane_zero (lane_zero)
    );

    always #4 clk = ~clk;

    // memory slave, random ack delay of 0 to 3 cycles
    initial begin
        void'($urandom(70235));
        forever begin
            @(negedge clk);
            if (!rst_n || wb_rsp.ack) begin
                wb_rsp  = '0;
                pending = 1'b0;
            end else if (wb_req.cyc && wb_req.stb) begin
                if (!pending) begin
                    delay   = $urandom % 4;
                    pending = 1'b1;
                end
                if (delay == 0) begin
                    wb_rsp.ack = 1'b1;
                    if (wb_req.we) begin
                        if ($isunknown(wb_req.adr)) begin
                            $display("store to an unknown address");
                            errors++;
                        end else begin
                            mem[wb_req.adr[7:0]] = wb_req.dat_w;
                        end
                        stores.push_back(wb_req);
                        wb_rsp.dat_r = '0;
                    end else if ($isunknown(wb_req.adr)) begin
                        // unknown base register reads back as zero
                        wb_rsp.dat_r = '0;
                    end else begin
                        wb_rsp.dat_r = mem[wb_req.adr[7:0]];
                    end
                end else begin
                    delay--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: program did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic instr_t reg_form(input opcode_t op, input logic [1:0] rd,
                                        input logic [1:0] rs1, input logic [1:0] rs2,
                                        input logic [1:0] imm2);
        instr_t w;
        w.r = '{opcode: op, rd: rd, rs1: rs1, rs2: rs2, spare: 2'b00, imm2: imm2};
        return w;
    endfunction

    function automatic instr_t imm_form(input opcode_t op, input logic [1:0] rd,
                                        input logic [1:0] rs1, input logic [5:0] imm6);
        instr_t w;
        w.i = '{opcode: op, rd: rd, rs1: rs1, imm6: imm6};
        return w;
    endfunction

    task automatic append_row(input instr_t ins, input int nst, input int adr,
                              input logic [3:0][DW-1:0] dat, input logic yl);
        rows[nrows] = '{instr: ins, nst: 3'(nst), adr: AW'(adr), dat: dat,
                        iz: cur_iz, lz: cur_lz, yl: yl};
        nrows++;
    endtask

    task automatic plain_row(input instr_t ins);
        append_row(ins, 0, 0, '0, 1'b0);
    endtask

    task automatic scalar_store_row(input instr_t ins, input int adr, input logic [DW-1:0] d);
        append_row(ins, 1, adr, {48'h0, d}, 1'b0);
    endtask

    task automatic vector_store_row(input instr_t ins, input int adr,
                                    input logic [DW-1:0] d0, input logic [DW-1:0] d1,
                                    input logic [DW-1:0] d2, input logic [DW-1:0] d3);
        append_row(ins, 4, adr, {d3, d2, d1, d0}, 1'b0);
    endtask

    task automatic flag_row(input instr_t ins, input logic iz, input logic lz);
        cur_iz = iz;
        cur_lz = lz;
        append_row(ins, 0, 0, '0, 1'b0);
    endtask

    // r1 holds 32, so stores land at 32 plus imm6
    task automatic build_program();
        plain_row(imm_form(I_LD, 2'd0, 2'd0, 6'd42));
        plain_row(imm_form(I_ADDI, 2'd1, 2'd0, 6'd32));
        plain_row(imm_form(I_LD, 2'd2, 2'd1, 6'd8));
        plain_row(imm_form(I_LD, 2'd3, 2'd1, 6'd9));
        plain_row(reg_form(I_ADD, 2'd0, 2'd2, 2'd3, 2'd0));
        scalar_store_row(imm_form(I_ST, 2'd0, 2'd1, 6'd16), 48, D0 + D1);
        plain_row(reg_form(I_SUB, 2'd0, 2'd2, 2'd3, 2'd0));
        scalar_store_row(imm_form(I_ST, 2'd0, 2'd1, 6'd17), 49, D0 - D1);
        plain_row(reg_form(I_MUL, 2'd0, 2'd2, 2'd3, 2'd0));
        scalar_store_row(imm_form(I_ST, 2'd0, 2'd1, 6'd18), 50, D0 * D1);
        plain_row(reg_form(I_NOT, 2'd0, 2'd2, 2'd0, 2'd0));
        scalar_store_row(imm_form(I_ST, 2'd0, 2'd1, 6'd19), 51, ~D0);
        plain_row(reg_form(I_AND, 2'd0, 2'd2, 2'd3, 2'd0));
        scalar_store_row(imm_form(I_ST, 2'd0, 2'd1, 6'd20), 52, D0 & D1);
        plain_row(imm_form(I_XORI, 2'd0, 2'd2, 6'h2A));
        scalar_store_row(imm_form(I_ST, 2'd0, 2'd1, 6'd21), 53, D0 ^ 16'h002A);
        plain_row(imm_form(I_MULI, 2'd0, 2'd2, 6'd37));
        scalar_store_row(imm_form(I_ST, 2'd0, 2'd1, 6'd22), 54, D0 * DW'(37));
        plain_row(imm_form(I_VLD, 2'd1, 2'd1, 6'd12));
        plain_row(imm_form(I_VLD, 2'd2, 2'd1, 6'd4));
        plain_row(reg_form(I_VV_ADD, 2'd3, 2'd1, 2'd2, 2'd0));
        vector_store_row(imm_form(I_VST, 2'd3, 2'd1, 6'd24), 56,
                         V0 + W0, V1 + W1, V2 + W2, V3 + W3);
        plain_row(reg_form(I_VF_MUL, 2'd0, 2'd1, 2'd3, 2'd0));
        vector_store_row(imm_form(I_VST, 2'd0, 2'd1, 6'd28), 60,
                         V0 * D1, V1 * D1, V2 * D1, V3 * D1);
        // scalar r2 replaces lane 2 of vector 2
        plain_row(reg_form(I_VFS, 2'd0, 2'd2, 2'd0, 2'd2));
        vector_store_row(imm_form(I_VST, 2'd0, 2'd1, 6'd32), 64, W0, W1, D0, W3);
        plain_row(reg_form(I_RED, 2'd0, 2'd1, 2'd0, 2'd0));
        scalar_store_row(imm_form(I_ST, 2'd0, 2'd1, 6'd36), 68, V0 + V1 + V2 + V3);
        plain_row(reg_form(I_SFL, 2'd0, 2'd2, 2'd0, 2'd3));
        scalar_store_row(imm_form(I_ST, 2'd0, 2'd1, 6'd37), 69, W3);
        flag_row(reg_form(I_IFLAG, 2'd0, 2'd2, 2'd2, 2'd0), 1'b1, 1'b0);
        flag_row(reg_form(I_LFLAG, 2'd0, 2'd3, 2'd3, 2'd0), 1'b1, 1'b1);
        flag_row(reg_form(I_IFLAG, 2'd0, 2'd2, 2'd3, 2'd0), 1'b0, 1'b1);
        flag_row(reg_form(I_LFLAG, 2'd0, 2'd2, 2'd3, 2'd0), 1'b0, 1'b0);
        append_row(reg_form(I_CTX, 2'd0, 2'd0, 2'd0, 2'd0), 0, 0, '0, 1'b1);
    endtask

    task automatic check_word(input string name, input logic [DW-1:0] got,
                              input logic [DW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_req(input string name, input wb_req_t got, input wb_req_t exp);
        checks++;
        if (got.adr !== exp.adr || got.dat_w !== exp.dat_w) begin
            errors++;
            $display("ERR %s adr %h data %h expected adr %h data %h",
                     name, got.adr, got.dat_w, exp.adr, exp.dat_w);
        end
    endtask

    task automatic run_row(input int r);
        wb_req_t got, exp;
        do @(posedge clk); while (!u_dut.instr_done);
        @(negedge clk);
        for (int b = 0; b < rows[r].nst; b++) begin
            exp       = '0;
            exp.adr   = rows[r].adr + AW'(b);
            exp.dat_w = rows[r].dat[b];
            if (stores.size() == 0) begin
                errors++;
                $display("row %0d: store %0d never reached the bus", r, b);
            end else begin
                got = stores.pop_front();
                check_req($sformatf("row %0d store", r), got, exp);
            end
        end
        check_word($sformatf("row %0d yield", r), DW'(yield), DW'(rows[r].yl));
        check_word($sformatf("row %0d int_zero", r), DW'(int_zero), DW'(rows[r].iz));
        check_word($sformatf("row %0d lane_zero", r), DW'(lane_zero), DW'(rows[r].lz));
    endtask

    initial begin
        wb_req_t first;
        clk     = 1'b0;
        rst_n   = 1'b0;
        wb_rsp  = '0;
        pending = 1'b0;
        delay   = 0;
        errors  = 0;
        checks  = 0;
        cycles  = 0;
        nrows   = 0;
        cur_iz  = 1'b0;
        cur_lz  = 1'b0;
        for (int a = 0; a < 256; a++) begin
            mem[a] = '0;
        end
        build_program();
        if (nrows != NROWS) begin
            errors++;
            $display("program table holds %0d rows instead of %0d", nrows, NROWS);
        end
        for (int r = 0; r < nrows; r++) begin
            mem[r] = rows[r].instr;
        end
        mem[36] = W0;
        mem[37] = W1;
        mem[38] = W2;
        mem[39] = W3;
        mem[40] = D0;
        mem[41] = D1;
        mem[44] = V0;
        mem[45] = V1;
        mem[46] = V2;
        mem[47] = V3;

        repeat (3) @(negedge clk);
        check_word("wb_req.cyc in reset", DW'(wb_req.cyc), '0);
        check_word("yield in reset", DW'(yield), '0);
        rst_n = 1'b1;
        @(negedge clk);
        first     = '0;
        first.adr = AW'(`VPU_RESET_PC);
        check_word("wb_req.cyc first fetch", DW'(wb_req.cyc), DW'(1));
        check_req("first fetch", wb_req, first);

        for (int r = 0; r < nrows; r++) begin
            run_row(r);
        end

        // yield lasts a single cycle
        @(negedge clk);
        check_word("yield after pulse", DW'(yield), '0);
        check_word("extra stores", DW'(stores.size()), '0);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hdl
hdl/vpu_isa_pkg.sv
hdl/vpu_bus_pkg.sv
hdl/instruction_decode_unit.sv
hdl/wb_arbiter.sv
hdl/fetch_unit.sv
hdl/execute_unit.sv
hdl/vpu_top.sv
tests/tb_vpu_top.sv

// File: Bender.yml
package:
  name: vpu_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/vpu_isa_pkg.sv
      - hdl/vpu_bus_pkg.sv
      - hdl/instruction_decode_unit.sv
      - hdl/wb_arbiter.sv
      - hdl/fetch_unit.sv
      - hdl/execute_unit.sv
      - hdl/vpu_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_vpu_top.sv
